// ==== design/beat_switch.sv ====
// purely combinational; assumes grant is one-hot or zero and held for a whole packet
`timescale 1ns/1ns
`default_nettype none

module beat_switch (
    input  logic [pkt_arb_pkg::num_inputs-1:0]                           grant,
    input  logic [pkt_arb_pkg::num_inputs-1:0]                           sink_valid,
    input  logic [pkt_arb_pkg::num_inputs-1:0][pkt_stream_pkg::data_w-1:0]    sink_data,
    input  logic [pkt_arb_pkg::num_inputs-1:0][pkt_stream_pkg::channel_w-1:0] sink_channel,
    input  logic [pkt_arb_pkg::num_inputs-1:0]                           sink_sop,
    input  logic [pkt_arb_pkg::num_inputs-1:0]                           sink_eop,
    output logic [pkt_arb_pkg::num_inputs-1:0]                           sink_ready,
    input  logic                                                         src_ready,
    output logic                                                         src_valid,
    output logic [pkt_stream_pkg::data_w-1:0]                            src_data,
    output logic [pkt_stream_pkg::channel_w-1:0]                         src_channel,
    output logic                                                         src_startofpacket,
    output logic                                                         src_endofpacket,
    output logic                                                         packet_done
);

    // --------------------
    // payload packing
    // --------------------

    logic [pkt_arb_pkg::num_inputs-1:0][pkt_stream_pkg::payload_w-1:0] sink_payload;
    logic [pkt_stream_pkg::payload_w-1:0]                              src_payload;

    // channel and data on top, framing bits at the bottom
    always_comb begin
        for (int i = 0; i < pkt_arb_pkg::num_inputs; i++) begin
            sink_payload[i] = {sink_channel[i], sink_data[i], sink_sop[i], sink_eop[i]};
        end
    end

    // --------------------
    // beat mux
    // --------------------

    // sum of products
    // with grant zero every term masks out and the output word is all zero
    always_comb begin
        src_payload = '0;
        for (int i = 0; i < pkt_arb_pkg::num_inputs; i++) begin
            src_payload |= sink_payload[i] & {pkt_stream_pkg::payload_w{grant[i]}};
        end
    end

    assign {src_channel, src_data, src_startofpacket, src_endofpacket} = src_payload;

    // only the granted input may present a beat
    assign src_valid = |(grant & sink_valid);

    // --------------------
    // ready and packet end
    // --------------------

    // ready goes back to the granted input only
    assign sink_ready = grant & {pkt_arb_pkg::num_inputs{src_ready}};

    // last beat of the packet actually leaving this cycle
    // the arbiter clears grant on this pulse
    assign packet_done = src_valid & src_ready & src_endofpacket;

endmodule

`default_nettype wire

// ==== design/grant_arbiter.sv ====
// grant is registered so each packet is followed by one idle arbitration cycle; four inputs only
`timescale 1ns/1ns
`default_nettype none

module grant_arbiter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [pkt_arb_pkg::num_inputs-1:0] valid_in,
    input  logic                               packet_done,
    output logic [pkt_arb_pkg::num_inputs-1:0] grant
);

    // --------------------
    // state
    // --------------------

    // one-hot pointer to the input that won last
    logic [pkt_arb_pkg::num_inputs-1:0]  last_grant;
    // packets left for the current winner minus one
    logic [pkt_arb_pkg::share_cnt_w-1:0] share_cnt;
    // set once the winner has used all its shares
    logic                                share_zero;

    // --------------------
    // next winner
    // --------------------

    logic                                arb_cycle;
    logic                                keep_winner;
    logic [pkt_arb_pkg::num_inputs-1:0]  after_mask;
    logic [pkt_arb_pkg::num_inputs-1:0]  cand;
    logic [pkt_arb_pkg::num_inputs-1:0]  next_winner;
    logic [pkt_arb_pkg::num_inputs-1:0]  next_grant;
    logic [pkt_arb_pkg::share_cnt_w-1:0] share_load;

    // idle with at least one request waiting
    assign arb_cycle = (grant == '0) && (|valid_in);

    // last winner still requesting and not out of shares
    assign keep_winner = (|(valid_in & last_grant)) && !share_zero;

    // mark every input strictly above the last winner
    always_comb begin
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < pkt_arb_pkg::num_inputs; i++) begin
            after_mask[i] = seen;
            if (last_grant[i]) begin
                seen = 1'b1;
            end
        end
    end

    // requests above the last winner come first, else wrap to the bottom
    assign cand = (|(valid_in & after_mask)) ? (valid_in & after_mask) : valid_in;

    // lowest set bit of the candidates gives the circular winner
    always_comb begin
        logic found;
        found = 1'b0;
        next_winner = '0;
        for (int i = 0; i < pkt_arb_pkg::num_inputs; i++) begin
            if (cand[i] && !found) begin
                next_winner[i] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign next_grant = keep_winner ? last_grant : next_winner;

    // share load for a fresh winner
    // and-or select over the table like the beat mux
    always_comb begin
        share_load = '0;
        for (int i = 0; i < pkt_arb_pkg::num_inputs; i++) begin
            share_load |= pkt_arb_pkg::share_table[i]
                        & {pkt_arb_pkg::share_cnt_w{next_winner[i]}};
        end
    end

    // --------------------
    // registers
    // --------------------

    // pointer resets to the top input so the first search starts at input 0
    // zero flag resets high so nobody is kept as a repeat winner
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant      <= '0;
            last_grant <= {1'b1, {(pkt_arb_pkg::num_inputs-1){1'b0}}};
            share_cnt  <= '0;
            share_zero <= 1'b1;
        end else if (packet_done) begin
            // drop grant for one arbitration cycle after every packet
            grant <= '0;
            if (share_cnt == '0) begin
                share_zero <= 1'b1;
            end else begin
                share_cnt <= share_cnt - {{(pkt_arb_pkg::share_cnt_w-1){1'b0}}, 1'b1};
            end
        end else if (arb_cycle) begin
            grant      <= next_grant;
            last_grant <= next_grant;
            // a repeat winner keeps its running count
            if (!keep_winner) begin
                share_cnt  <= share_load;
                share_zero <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/pkt_arb_pkg.sv ====
// arbitration constants for exactly four inputs; share entries are loaded as count minus one
`default_nettype none

package pkt_arb_pkg;

    // --------------------
    // inputs
    // --------------------

    // number of source ports feeding the mux
    // the grant vector is one bit per input
    localparam int num_inputs = 4;

    // --------------------
    // shares
    // --------------------

    // share counter width
    // must hold the largest load value below
    localparam int share_cnt_w = 5;

    // packets allowed per win for each input
    //
    //   input | shares | load value
    //   0     |   5    |   4
    //   1     |   5    |   4
    //   2     |   20   |   19
    //   3     |   20   |   19
    //
    // stored minus one since the counter counts down to zero and the
    // zero flag only rises once the last allowed packet has ended
    // entry [0] is the rightmost field of the concatenation
    localparam logic [num_inputs-1:0][share_cnt_w-1:0] share_table = {
        5'd19,
        5'd19,
        5'd4,
        5'd4
    };

endpackage

`default_nettype wire

// ==== design/pkt_mux_top.sv ====
// four fixed inputs; sources must hold a beat stable while valid is high and ready is low
`timescale 1ns/1ns
`default_nettype none

module pkt_mux_top (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 sink0_valid,
    input  logic [pkt_stream_pkg::data_w-1:0]    sink0_data,
    input  logic [pkt_stream_pkg::channel_w-1:0] sink0_channel,
    input  logic                                 sink0_startofpacket,
    input  logic                                 sink0_endofpacket,
    output logic                                 sink0_ready,
    input  logic                                 sink1_valid,
    input  logic [pkt_stream_pkg::data_w-1:0]    sink1_data,
    input  logic [pkt_stream_pkg::channel_w-1:0] sink1_channel,
    input  logic                                 sink1_startofpacket,
    input  logic                                 sink1_endofpacket,
    output logic                                 sink1_ready,
    input  logic                                 sink2_valid,
    input  logic [pkt_stream_pkg::data_w-1:0]    sink2_data,
    input  logic [pkt_stream_pkg::channel_w-1:0] sink2_channel,
    input  logic                                 sink2_startofpacket,
    input  logic                                 sink2_endofpacket,
    output logic                                 sink2_ready,
    input  logic                                 sink3_valid,
    input  logic [pkt_stream_pkg::data_w-1:0]    sink3_data,
    input  logic [pkt_stream_pkg::channel_w-1:0] sink3_channel,
    input  logic                                 sink3_startofpacket,
    input  logic                                 sink3_endofpacket,
    output logic                                 sink3_ready,
    output logic                                 src_valid,
    output logic [pkt_stream_pkg::data_w-1:0]    src_data,
    output logic [pkt_stream_pkg::channel_w-1:0] src_channel,
    output logic                                 src_startofpacket,
    output logic                                 src_endofpacket,
    input  logic                                 src_ready
);

    // --------------------
    // regrouped inputs
    // --------------------

    // index n of each vector belongs to sink n
    logic [pkt_arb_pkg::num_inputs-1:0]                                   valid_in;
    logic [pkt_arb_pkg::num_inputs-1:0][pkt_stream_pkg::data_w-1:0]    data_in;
    logic [pkt_arb_pkg::num_inputs-1:0][pkt_stream_pkg::channel_w-1:0] channel_in;
    logic [pkt_arb_pkg::num_inputs-1:0]                                   sop_in;
    logic [pkt_arb_pkg::num_inputs-1:0]                                   eop_in;
    logic [pkt_arb_pkg::num_inputs-1:0]                                   ready_out;
    logic [pkt_arb_pkg::num_inputs-1:0]                                   grant;
    logic                                                                 packet_done;

    assign valid_in   = {sink3_valid, sink2_valid, sink1_valid, sink0_valid};
    assign data_in    = {sink3_data, sink2_data, sink1_data, sink0_data};
    assign channel_in = {sink3_channel, sink2_channel, sink1_channel, sink0_channel};
    assign sop_in     = {sink3_startofpacket, sink2_startofpacket,
                         sink1_startofpacket, sink0_startofpacket};
    assign eop_in     = {sink3_endofpacket, sink2_endofpacket,
                         sink1_endofpacket, sink0_endofpacket};
    assign {sink3_ready, sink2_ready, sink1_ready, sink0_ready} = ready_out;

    // --------------------
    // grant then switch
    // --------------------

    grant_arbiter arb_i (
        .clk         (clk),
        .reset       (reset),
        .valid_in    (valid_in),
        .packet_done (packet_done),
        .grant       (grant)
    );

    beat_switch switch_i (
        .grant             (grant),
        .sink_valid        (valid_in),
        .sink_data         (data_in),
        .sink_channel      (channel_in),
        .sink_sop          (sop_in),
        .sink_eop          (eop_in),
        .sink_ready        (ready_out),
        .src_ready         (src_ready),
        .src_valid         (src_valid),
        .src_data          (src_data),
        .src_channel       (src_channel),
        .src_startofpacket (src_startofpacket),
        .src_endofpacket   (src_endofpacket),
        .packet_done       (packet_done)
    );

endmodule

`default_nettype wire

// ==== design/pkt_stream_pkg.sv ====
// data is opaque to the mux and the field widths are fixed for all four inputs
`default_nettype none

package pkt_stream_pkg;

    // --------------------
    // beat fields
    // --------------------

    // payload word carried on every beat
    // no bit of it is decoded inside the mux
    localparam int data_w = 32;

    // channel tag that travels with the beat
    // passed through untouched like the data
    localparam int channel_w = 8;

    // --------------------
    // packed beat
    // --------------------

    // the switch packs one beat into a single word before the and-or mux
    // layout from msb to lsb is
    //   channel
    //   data
    //   startofpacket
    //   endofpacket
    // two framing bits sit at the bottom
    localparam int payload_w = channel_w + data_w + 2;

endpackage

`default_nettype wire

// ==== pkt_mux.f ====
design/pkt_stream_pkg.sv
design/pkt_arb_pkg.sv
design/grant_arbiter.sv
design/beat_switch.sv
design/pkt_mux_top.sv
testbench/pkt_mux_checker.sv
testbench/pkt_mux_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pkt_mux testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module pkt_mux_tb \
    -Mdir obj_dir -o pkt_mux_sim \
    -f pkt_mux.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/pkt_mux_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation PASSED" "$log"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $log"
    exit 1
fi

// ==== testbench/pkt_mux_cases.txt ====
# columns: name in0 in1 in2 in3 beats bp
# in0..in3 are packets queued per input, beats is packet length, bp=1 randomizes src_ready
#
# one input alone
single_in0        4  0  0  0  1  0
single_in3_long   0  0  0  3  6  0
single_in1_bp     0  6  0  0  3  1
#
# inputs 0 and 1 swap every five packets
pair_01          12 12  0  0  1  0
pair_01_multi     7  8  0  0  2  0
pair_01_bp       12 12  0  0  2  1
#
# input 2 sends twenty per turn, input 1 five, input 1 drains first
pair_12           0 12 45  0  1  0
pair_12_bp        0 12 45  0  2  1
pair_23           0  0 25 21  1  0
#
# wrap from input 3 back to input 1
wrap_13           0  6  0 30  1  1
#
# all four inputs with multi-beat packets
all_four          7  9 25 22  4  0
all_four_bp       7  9 25 22  4  1
all_long_bp       3  3  3  3  9  1

// ==== testbench/pkt_mux_checker.sv ====
// sampled on the rising clock edge; the grant hold check only covers packets longer than one beat
`timescale 1ns/1ns
`default_nettype none

module pkt_mux_checker (
    input logic                               clk,
    input logic                               reset,
    input logic [pkt_arb_pkg::num_inputs-1:0] grant,
    input logic [pkt_arb_pkg::num_inputs-1:0] ready_out,
    input logic                               src_valid,
    input logic                               src_ready,
    input logic                               src_startofpacket,
    input logic                               packet_done
);

    // --------------------
    // packet tracking
    // --------------------

    // high from a transferred start beat up to its packet_done
    logic                               in_packet;
    logic [pkt_arb_pkg::num_inputs-1:0] held_grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_packet  <= 1'b0;
            held_grant <= '0;
        end else if (packet_done) begin
            in_packet <= 1'b0;
        end else if (src_valid && src_ready && src_startofpacket) begin
            in_packet  <= 1'b1;
            held_grant <= grant;
        end
    end

    // --------------------
    // properties
    // --------------------

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else $error("grant has more than one bit set");

    // the winner may not change in the middle of a packet
    grant_held: assert property (@(posedge clk) disable iff (reset)
        in_packet |-> grant == held_grant)
        else $error("grant changed inside a packet");

    idle_after_reset: assert property (@(posedge clk) $fell(reset) |-> !src_valid)
        else $error("src_valid high in the first cycle after reset");

    // ready as seen on the sink ports, bit n is sink n
    ready_granted_only: assert property (@(posedge clk) disable iff (reset)
        (ready_out & ~grant) == '0)
        else $error("ready high on an input without grant");

endmodule

bind pkt_mux_top pkt_mux_checker checker_i (
    .clk               (clk),
    .reset             (reset),
    .grant             (grant),
    .ready_out         ({sink3_ready, sink2_ready, sink1_ready, sink0_ready}),
    .src_valid         (src_valid),
    .src_ready         (src_ready),
    .src_startofpacket (src_startofpacket),
    .packet_done       (packet_done)
);

`default_nettype wire

// ==== testbench/pkt_mux_tb.sv ====
// reads testbench/pkt_mux_cases.txt from the project root; the DUT is reset before every case
`timescale 1ns/1ns
`default_nettype none

module pkt_mux_tb;

    typedef logic [pkt_stream_pkg::data_w-1:0]    data_t;
    typedef logic [pkt_stream_pkg::channel_w-1:0] chan_t;
    typedef logic [pkt_arb_pkg::num_inputs-1:0]   port_vec_t;
    typedef logic [1:0]                           framing_t;

    localparam int max_cases = 32;

    // --------------------
    // DUT signals
    // --------------------

    logic                                   clk = 1'b0;
    logic                                   reset;
    port_vec_t                              sink_valid;
    port_vec_t                              sink_sop;
    port_vec_t                              sink_eop;
    data_t                                  sink_data [pkt_arb_pkg::num_inputs];
    chan_t                                  sink_channel [pkt_arb_pkg::num_inputs];
    wire [pkt_arb_pkg::num_inputs-1:0]      sink_ready;
    logic                                   src_ready;
    wire                                    src_valid;
    wire [pkt_stream_pkg::data_w-1:0]       src_data;
    wire [pkt_stream_pkg::channel_w-1:0]    src_channel;
    wire                                    src_startofpacket;
    wire                                    src_endofpacket;

    // case table and expected packet order
    string names [max_cases];
    int    counts [max_cases][pkt_arb_pkg::num_inputs];
    int    beats_per [max_cases];
    bit    bp_flag [max_cases];
    int    n_cases;
    string case_name;
    int    exp_in [$];
    int    exp_pkt [$];
    int    seed = 32'hb388;
    int    watchdog_ns = 0;

    always #20 clk = ~clk;

    pkt_mux_top dut_i (
        .clk (clk), .reset (reset),
        .sink0_valid (sink_valid[0]), .sink0_data (sink_data[0]),
        .sink0_channel (sink_channel[0]), .sink0_startofpacket (sink_sop[0]),
        .sink0_endofpacket (sink_eop[0]), .sink0_ready (sink_ready[0]),
        .sink1_valid (sink_valid[1]), .sink1_data (sink_data[1]),
        .sink1_channel (sink_channel[1]), .sink1_startofpacket (sink_sop[1]),
        .sink1_endofpacket (sink_eop[1]), .sink1_ready (sink_ready[1]),
        .sink2_valid (sink_valid[2]), .sink2_data (sink_data[2]),
        .sink2_channel (sink_channel[2]), .sink2_startofpacket (sink_sop[2]),
        .sink2_endofpacket (sink_eop[2]), .sink2_ready (sink_ready[2]),
        .sink3_valid (sink_valid[3]), .sink3_data (sink_data[3]),
        .sink3_channel (sink_channel[3]), .sink3_startofpacket (sink_sop[3]),
        .sink3_endofpacket (sink_eop[3]), .sink3_ready (sink_ready[3]),
        .src_valid (src_valid), .src_data (src_data), .src_channel (src_channel),
        .src_startofpacket (src_startofpacket), .src_endofpacket (src_endofpacket),
        .src_ready (src_ready)
    );

    // --------------------
    // checks
    // --------------------

    task automatic stop_on_error();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string what, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error: %0s %0s expected %h actual %h", case_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_channel(input string what, input chan_t exp, input chan_t act);
        if (act !== exp) begin
            $display("error: %0s %0s expected %h actual %h", case_name, what, exp, act);
            stop_on_error();
        end
    endtask

    // framing is {startofpacket, endofpacket}
    task automatic check_framing(input string what, input framing_t exp, input framing_t act);
        if (act !== exp) begin
            $display("error: %0s %0s expected %b actual %b", case_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_ready(input string what, input port_vec_t exp, input port_vec_t act);
        if (act !== exp) begin
            $display("error: %0s %0s expected %b actual %b", case_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %0s %0s expected %b actual %b", case_name, what, exp, act);
            stop_on_error();
        end
    endtask

    // --------------------
    // stimulus helpers
    // --------------------

    // input index in the top nibble, packet number in the middle, beat at the bottom
    function automatic data_t beat_word(input int port, input int pkt, input int beat);
        return data_t'((port << 28) | (pkt << 12) | beat);
    endfunction

    // packets allowed per win, 5 5 20 20
    function automatic int share_count(input int port);
        return (port < 2) ? 5 : 20;
    endfunction

    task automatic load_cases();
        int              fd;
        int              rc;
        int              c [pkt_arb_pkg::num_inputs];
        int              beats;
        int              bp;
        int              total_beats;
        int              total_pkts;
        string           line;
        logic [8*32-1:0] name_buf;
        total_beats = 0;
        total_pkts  = 0;
        n_cases     = 0;
        fd = $fopen("testbench/pkt_mux_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file testbench/pkt_mux_cases.txt");
            stop_on_error();
        end
        while ($fgets(line, fd) != 0) begin
            // skip blank lines and comment lines
            if (line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%s %d %d %d %d %d %d",
                             name_buf, c[0], c[1], c[2], c[3], beats, bp);
                if (rc != 7 || beats < 1 || n_cases == max_cases) begin
                    $display("bad or surplus line in the case file: %0s", line);
                    stop_on_error();
                end
                names[n_cases]     = $sformatf("%0s", name_buf);
                beats_per[n_cases] = beats;
                bp_flag[n_cases]   = (bp != 0);
                for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
                    counts[n_cases][n] = c[n];
                    total_pkts += c[n];
                    total_beats += c[n] * beats;
                end
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            $display("the case file holds no test cases");
            stop_on_error();
        end
        // four cycles per beat under back-pressure, one idle cycle per packet,
        // reset and drain per case, then some margin
        watchdog_ns = (4 * total_beats + total_pkts + 20 * n_cases + 100) * 40;
    endtask

    // --------------------
    // reference order
    // --------------------

    // weighted round-robin over the packet queues, cycle timing plays no part
    task automatic build_order(input int ci);
        int left [pkt_arb_pkg::num_inputs];
        int sent [pkt_arb_pkg::num_inputs];
        int last;
        int shares;
        int winner;
        exp_in.delete();
        exp_pkt.delete();
        for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
            left[n] = counts[ci][n];
            sent[n] = 0;
        end
        // search after reset starts at input 0
        last   = pkt_arb_pkg::num_inputs - 1;
        shares = 0;
        while (left.sum() > 0) begin
            winner = last;
            if (left[last] == 0 || shares == 0) begin
                winner = -1;
                for (int k = 1; k <= pkt_arb_pkg::num_inputs; k++) begin
                    if (winner < 0 && left[(last + k) % pkt_arb_pkg::num_inputs] > 0) begin
                        winner = (last + k) % pkt_arb_pkg::num_inputs;
                    end
                end
                shares = share_count(winner);
            end
            exp_in.push_back(winner);
            exp_pkt.push_back(sent[winner]);
            sent[winner]++;
            left[winner]--;
            shares--;
            last = winner;
        end
    endtask

    // --------------------
    // one case
    // --------------------

    task automatic run_case(input int ci);
        int        pkt_idx [pkt_arb_pkg::num_inputs];
        int        beat_idx [pkt_arb_pkg::num_inputs];
        bit        fired [pkt_arb_pkg::num_inputs];
        int        rnd;
        int        got;
        int        total;
        int        pos;
        int        out_beat;
        int        beats;
        bit        idle_due;
        port_vec_t exp_ready;
        case_name = names[ci];
        beats     = beats_per[ci];
        build_order(ci);
        // reset for 5 cycles with every source idle
        @(negedge clk);
        reset      = 1'b1;
        sink_valid = '0;
        src_ready  = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        #10;
        check_ready("sink_ready after reset", '0, sink_ready);
        for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
            pkt_idx[n]  = 0;
            beat_idx[n] = 0;
            fired[n]    = 1'b0;
        end
        got      = 0;
        pos      = 0;
        out_beat = 0;
        idle_due = 1'b1;
        total    = exp_in.size() * beats;
        while (got < total) begin
            @(negedge clk);
            // a source moves on only after its beat was taken
            for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
                if (fired[n]) begin
                    beat_idx[n]++;
                    if (beat_idx[n] == beats) begin
                        beat_idx[n] = 0;
                        pkt_idx[n]++;
                    end
                end
                sink_valid[n]   = pkt_idx[n] < counts[ci][n];
                sink_data[n]    = beat_word(n, pkt_idx[n], beat_idx[n]);
                sink_channel[n] = chan_t'(n);
                sink_sop[n]     = beat_idx[n] == 0;
                sink_eop[n]     = beat_idx[n] == beats - 1;
            end
            rnd       = $random(seed);
            src_ready = bp_flag[ci] ? rnd[0] : 1'b1;
            // sample mid cycle where every level is settled
            #10;
            for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
                fired[n] = sink_valid[n] && sink_ready[n];
            end
            // registered grant, so exactly one idle cycle comes before each packet
            exp_ready = idle_due ? '0 : port_vec_t'(src_ready) << exp_in[pos];
            check_valid($sformatf("src_valid at packet %0d", pos), !idle_due, src_valid);
            check_ready($sformatf("sink_ready at packet %0d", pos), exp_ready, sink_ready);
            if (idle_due) begin
                idle_due = 1'b0;
            end else begin
                // checked while stalled too, so the beat has to stay put
                check_data($sformatf("data of packet %0d", pos),
                           beat_word(exp_in[pos], exp_pkt[pos], out_beat), src_data);
                check_channel($sformatf("channel of packet %0d", pos),
                              chan_t'(exp_in[pos]), src_channel);
                check_framing($sformatf("framing of packet %0d", pos),
                              {out_beat == 0, out_beat == beats - 1},
                              {src_startofpacket, src_endofpacket});
                if (src_ready) begin
                    got++;
                    out_beat++;
                    if (out_beat == beats) begin
                        out_beat = 0;
                        pos++;
                        idle_due = 1'b1;
                    end
                end
            end
        end
    endtask

    // --------------------
    // main flow and watchdog
    // --------------------

    initial begin
        reset      = 1'b1;
        sink_valid = '0;
        sink_sop   = '0;
        sink_eop   = '0;
        src_ready  = 1'b1;
        for (int n = 0; n < pkt_arb_pkg::num_inputs; n++) begin
            sink_data[n]    = '0;
            sink_channel[n] = '0;
        end
        load_cases();
        for (int ci = 0; ci < n_cases; ci++) begin
            run_case(ci);
        end
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("the run did not finish in time, the DUT seems to hang in case %0s",
                 case_name);
        stop_on_error();
    end

endmodule

`default_nettype wire
